//--- revo_phase_pkg.sv
package revo_phase_pkg;

	// Word and counter widths --------------------
	localparam int SAMPLE_BITS = 4;
	// About 99.4k revolutions per second, so 33 bits roll over about once a day
	localparam int HIST_WIDTH = 33;
	localparam int PULSE_COUNT_WIDTH = 35;
	// Hardware samples the marker activity roughly every 2^19 cycles
	localparam int ACTIVITY_BITS = 8;

	typedef logic [SAMPLE_BITS-1:0] sample_word_t;
	typedef logic [1:0] phase_t;
	typedef logic [HIST_WIDTH-1:0] hist_count_t;
	typedef logic [PULSE_COUNT_WIDTH-1:0] pulse_count_t;
	typedef logic [ACTIVITY_BITS-1:0] activity_count_t;

	// Lock and startup limits --------------------
	// Hardware latches the phase after 131072 markers
	localparam pulse_count_t PULSE_COUNT_MIN = pulse_count_t'(64);
	// Hardware tolerates 16384 cycles of lost lock
	localparam int NOT_LOCKED_LIMIT = 64;
	localparam int NOT_LOCKED_COUNT_WIDTH = $clog2(NOT_LOCKED_LIMIT + 1);
	typedef logic [NOT_LOCKED_COUNT_WIDTH-1:0] not_locked_count_t;
	localparam not_locked_count_t NOT_LOCKED_MAX = not_locked_count_t'(NOT_LOCKED_LIMIT);

	localparam int STARTUP_CYCLES = 32;
	localparam int STARTUP_COUNT_WIDTH = $clog2(STARTUP_CYCLES);
	typedef logic [STARTUP_COUNT_WIDTH-1:0] startup_count_t;
	localparam startup_count_t STARTUP_LAST = startup_count_t'(STARTUP_CYCLES - 1);

	// Marker arrival words, one per phase
	localparam sample_word_t PATTERN_00 = 4'b1110;
	localparam sample_word_t PATTERN_01 = 4'b1100;
	localparam sample_word_t PATTERN_10 = 4'b1000;
	localparam sample_word_t PATTERN_11 = 4'b1111;

	typedef struct packed {
		phase_t candidate;
		pulse_count_t pulse_count;
	} phase_vote_t;

	typedef struct packed {
		logic phase_locked;
		phase_t phase_select;
	} lock_status_t;

	typedef struct packed {
		logic first_half;
		logic second_half;
	} ddr_pair_t;

	// Plain clock pattern, and the inverted one that marks a revolution
	localparam ddr_pair_t DDR_IDLE = '{first_half: 1'b1, second_half: 1'b0};
	localparam ddr_pair_t DDR_MARK = '{first_half: 1'b0, second_half: 1'b1};

endpackage

//--- revo_edge_pulser.sv
`timescale 1ns/1ps

module revo_edge_pulser #(
	parameter type payload_t = logic
) (
	input logic clock127,
	input logic oserdes_reset,
	input logic clear,
	input payload_t in_word,
	output payload_t out_word
);

	payload_t prev_word;

	// Pass a word only when it follows an idle word
	always_ff @(posedge clock127 or posedge oserdes_reset) begin
		if (oserdes_reset) begin
			prev_word <= '0;
			out_word <= '0;
		end else if (clear) begin
			prev_word <= '0;
			out_word <= '0;
		end else begin
			prev_word <= in_word;
			if (prev_word == '0) begin
				out_word <= in_word;
			end else begin
				out_word <= '0;
			end
		end
	end

endmodule

//--- phase_histogram.sv
`timescale 1ns/1ps

module phase_histogram (
	input logic clock127,
	input logic oserdes_reset,
	input logic histogram_clear,
	input revo_phase_pkg::sample_word_t pulse_word,
	output revo_phase_pkg::phase_vote_t vote
);

	revo_phase_pkg::hist_count_t hist_00;
	revo_phase_pkg::hist_count_t hist_01;
	revo_phase_pkg::hist_count_t hist_10;
	revo_phase_pkg::hist_count_t hist_11;
	revo_phase_pkg::pulse_count_t pulse_count;

	// Stage 1 winners, one per half
	revo_phase_pkg::hist_count_t best_0x;
	revo_phase_pkg::hist_count_t best_1x;
	logic sel_0x;
	logic sel_1x;

	// Stage 2 winner
	revo_phase_pkg::phase_t candidate;

	// Arrival counters --------------------
	always_ff @(posedge clock127 or posedge oserdes_reset) begin
		if (oserdes_reset) begin
			hist_00 <= '0;
			hist_01 <= '0;
			hist_10 <= '0;
			hist_11 <= '0;
			pulse_count <= '0;
		end else if (histogram_clear) begin
			hist_00 <= '0;
			hist_01 <= '0;
			hist_10 <= '0;
			hist_11 <= '0;
			pulse_count <= '0;
		end else begin
			case (pulse_word)
				revo_phase_pkg::PATTERN_00: begin
					hist_00 <= hist_00 + 1'b1;
					pulse_count <= pulse_count + 1'b1;
				end
				revo_phase_pkg::PATTERN_01: begin
					hist_01 <= hist_01 + 1'b1;
					pulse_count <= pulse_count + 1'b1;
				end
				revo_phase_pkg::PATTERN_10: begin
					hist_10 <= hist_10 + 1'b1;
					pulse_count <= pulse_count + 1'b1;
				end
				revo_phase_pkg::PATTERN_11: begin
					hist_11 <= hist_11 + 1'b1;
					pulse_count <= pulse_count + 1'b1;
				end
				// Partial or glitched words do not count
				default: begin
				end
			endcase
		end
	end

	// Best phase search --------------------
	// Equal counts favour the even entry of each half
	always_ff @(posedge clock127 or posedge oserdes_reset) begin
		if (oserdes_reset) begin
			sel_0x <= 1'b0;
			sel_1x <= 1'b0;
			best_0x <= '0;
			best_1x <= '0;
		end else if (histogram_clear) begin
			sel_0x <= 1'b0;
			sel_1x <= 1'b0;
			best_0x <= '0;
			best_1x <= '0;
		end else begin
			sel_0x <= (hist_00 < hist_01);
			best_0x <= (hist_00 < hist_01) ? hist_01 : hist_00;
			sel_1x <= (hist_10 < hist_11);
			best_1x <= (hist_10 < hist_11) ? hist_11 : hist_10;
		end
	end

	// Equal halves favour the 0x half
	always_ff @(posedge clock127 or posedge oserdes_reset) begin
		if (oserdes_reset) begin
			candidate <= '0;
		end else if (histogram_clear) begin
			candidate <= '0;
		end else if (best_0x < best_1x) begin
			candidate <= {1'b1, sel_1x};
		end else begin
			candidate <= {1'b0, sel_0x};
		end
	end

	assign vote.candidate = candidate;
	assign vote.pulse_count = pulse_count;

endmodule

//--- revo_lock_control.sv
`timescale 1ns/1ps

module revo_lock_control (
	input logic clock127,
	input logic oserdes_reset,
	input logic pll_locked,
	input revo_phase_pkg::phase_vote_t vote,
	output logic histogram_clear,
	output logic encoder_enable,
	output logic pll_reset,
	output revo_phase_pkg::lock_status_t lock_status
);

	revo_phase_pkg::startup_count_t startup_count;
	logic in_startup;
	revo_phase_pkg::not_locked_count_t not_locked_count;
	logic lost_lock_pulse;
	logic phase_locked;
	revo_phase_pkg::phase_t phase_select;

	// Startup --------------------
	// PLL reset is held for a fixed number of cycles after power up
	always_ff @(posedge clock127 or posedge oserdes_reset) begin
		if (oserdes_reset) begin
			startup_count <= '0;
			in_startup <= 1'b1;
		end else if (in_startup) begin
			startup_count <= startup_count + 1'b1;
			if (startup_count == revo_phase_pkg::STARTUP_LAST) begin
				in_startup <= 1'b0;
			end
		end
	end

	// Lost lock watchdog --------------------
	always_ff @(posedge clock127 or posedge oserdes_reset) begin
		if (oserdes_reset) begin
			not_locked_count <= '0;
			lost_lock_pulse <= 1'b0;
		end else if (in_startup || pll_locked) begin
			not_locked_count <= '0;
			lost_lock_pulse <= 1'b0;
		end else if (lost_lock_pulse) begin
			// One cycle of PLL reset, then count again
			not_locked_count <= '0;
			lost_lock_pulse <= 1'b0;
		end else if (not_locked_count == revo_phase_pkg::NOT_LOCKED_MAX) begin
			not_locked_count <= '0;
			lost_lock_pulse <= 1'b1;
		end else begin
			not_locked_count <= not_locked_count + 1'b1;
		end
	end

	assign pll_reset = in_startup | lost_lock_pulse;
	assign histogram_clear = in_startup | pll_reset | ~pll_locked;

	// Phase lock --------------------
	// The stage 2 candidate at this point covers exactly the first PULSE_COUNT_MIN markers
	always_ff @(posedge clock127 or posedge oserdes_reset) begin
		if (oserdes_reset) begin
			phase_locked <= 1'b0;
			phase_select <= '0;
		end else if (histogram_clear) begin
			phase_locked <= 1'b0;
			phase_select <= '0;
		end else if (!phase_locked && (vote.pulse_count > revo_phase_pkg::PULSE_COUNT_MIN)) begin
			phase_locked <= 1'b1;
			phase_select <= vote.candidate;
		end
	end

	// Encoder starts one cycle after the lock but stops together with it
	always_ff @(posedge clock127 or posedge oserdes_reset) begin
		if (oserdes_reset) begin
			encoder_enable <= 1'b0;
		end else begin
			encoder_enable <= phase_locked & ~histogram_clear;
		end
	end

	assign lock_status.phase_locked = phase_locked;
	assign lock_status.phase_select = phase_select;

endmodule

//--- trigger_encoder.sv
`timescale 1ns/1ps

module trigger_encoder (
	input logic clock127,
	input logic oserdes_reset,
	input logic encoder_enable,
	input revo_phase_pkg::sample_word_t pulse_word,
	output revo_phase_pkg::ddr_pair_t trigger_ddr
);

	logic long_trg;
	logic short_trg;
	logic pulser_clear;

	assign pulser_clear = ~encoder_enable;

	// Any arrival phase counts as a marker
	always_ff @(posedge clock127 or posedge oserdes_reset) begin
		if (oserdes_reset) begin
			long_trg <= 1'b0;
		end else if (!encoder_enable) begin
			long_trg <= 1'b0;
		end else begin
			long_trg <= |pulse_word;
		end
	end

	revo_edge_pulser #(
		.payload_t(logic)
	) long_to_short (
		.clock127(clock127),
		.oserdes_reset(oserdes_reset),
		.clear(pulser_clear),
		.in_word(long_trg),
		.out_word(short_trg)
	);

	// Marker inverts the clock pattern for one cycle
	always_ff @(posedge clock127 or posedge oserdes_reset) begin
		if (oserdes_reset) begin
			trigger_ddr <= revo_phase_pkg::DDR_IDLE;
		end else if (encoder_enable && short_trg) begin
			trigger_ddr <= revo_phase_pkg::DDR_MARK;
		end else begin
			trigger_ddr <= revo_phase_pkg::DDR_IDLE;
		end
	end

endmodule

//--- revo_activity_monitor.sv
`timescale 1ns/1ps

module revo_activity_monitor (
	input logic clock127,
	input logic oserdes_reset,
	input revo_phase_pkg::sample_word_t pulse_word,
	output logic revo_led
);

	revo_phase_pkg::activity_count_t activity_count;
	logic marker_seen;
	logic period_end;

	assign period_end = &activity_count;

	// Free running sample period
	always_ff @(posedge clock127 or posedge oserdes_reset) begin
		if (oserdes_reset) begin
			activity_count <= '0;
		end else begin
			activity_count <= activity_count + 1'b1;
		end
	end

	// A marker in the last cycle of a period still counts for that period
	always_ff @(posedge clock127 or posedge oserdes_reset) begin
		if (oserdes_reset) begin
			marker_seen <= 1'b0;
			revo_led <= 1'b0;
		end else if (period_end) begin
			revo_led <= marker_seen | (|pulse_word);
			marker_seen <= 1'b0;
		end else if (|pulse_word) begin
			marker_seen <= 1'b1;
		end
	end

endmodule

//--- revo_encoder_top.sv
`timescale 1ns/1ps

module revo_encoder_top (
	input logic clock127,
	input logic oserdes_reset,
	input revo_phase_pkg::sample_word_t revo_word,
	input logic pll_locked,
	output logic pll_reset,
	output revo_phase_pkg::lock_status_t lock_status,
	output revo_phase_pkg::ddr_pair_t trigger_ddr,
	output logic revo_led
);

	revo_phase_pkg::sample_word_t pulse_word;
	revo_phase_pkg::phase_vote_t vote;
	logic histogram_clear;
	logic encoder_enable;

	// Marker front end --------------------
	revo_edge_pulser #(
		.payload_t(revo_phase_pkg::sample_word_t)
	) revo_pulser (
		.clock127(clock127),
		.oserdes_reset(oserdes_reset),
		.clear(1'b0),
		.in_word(revo_word),
		.out_word(pulse_word)
	);

	phase_histogram histogram (
		.clock127(clock127),
		.oserdes_reset(oserdes_reset),
		.histogram_clear(histogram_clear),
		.pulse_word(pulse_word),
		.vote(vote)
	);

	revo_lock_control control (
		.clock127(clock127),
		.oserdes_reset(oserdes_reset),
		.pll_locked(pll_locked),
		.vote(vote),
		.histogram_clear(histogram_clear),
		.encoder_enable(encoder_enable),
		.pll_reset(pll_reset),
		.lock_status(lock_status)
	);

	// Outputs --------------------
	trigger_encoder encoder (
		.clock127(clock127),
		.oserdes_reset(oserdes_reset),
		.encoder_enable(encoder_enable),
		.pulse_word(pulse_word),
		.trigger_ddr(trigger_ddr)
	);

	revo_activity_monitor activity (
		.clock127(clock127),
		.oserdes_reset(oserdes_reset),
		.pulse_word(pulse_word),
		.revo_led(revo_led)
	);

endmodule

//--- tb_revo_encoder.sv
`timescale 1ns/1ps

module tb_revo_encoder;

	localparam logic [1:0] IDLE_PAIR = 2'b10;
	localparam logic [1:0] MARK_PAIR = 2'b01;
	localparam int MIN_MARKERS = int'(revo_phase_pkg::PULSE_COUNT_MIN);
	localparam int LED_TIMEOUT = 2 * (2 ** revo_phase_pkg::ACTIVITY_BITS) + 8;
	localparam int PULSE_TIMEOUT = revo_phase_pkg::NOT_LOCKED_LIMIT + 4;
	// Arrival words indexed by phase, phase 00 in the low nibble
	localparam logic [15:0] PATTERNS = {revo_phase_pkg::PATTERN_11, revo_phase_pkg::PATTERN_10,
		revo_phase_pkg::PATTERN_01, revo_phase_pkg::PATTERN_00};

	logic clock127;
	logic oserdes_reset;
	revo_phase_pkg::sample_word_t revo_word;
	logic pll_locked;
	logic pll_reset;
	revo_phase_pkg::lock_status_t lock_status;
	revo_phase_pkg::ddr_pair_t trigger_ddr;
	logic revo_led;

	int error_count = 0;
	int check_count = 0;
	logic check_trigger = 1'b0;
	int phase_counts [4];
	int pattern_total;
	revo_phase_pkg::sample_word_t last_word = '0;
	logic [3:0] event_line = '0;
	logic [1:0] expected_pair;

	revo_encoder_top uut (
		.clock127(clock127),
		.oserdes_reset(oserdes_reset),
		.revo_word(revo_word),
		.pll_locked(pll_locked),
		.pll_reset(pll_reset),
		.lock_status(lock_status),
		.trigger_ddr(trigger_ddr),
		.revo_led(revo_led)
	);

	initial begin
		clock127 = 1'b0;
		forever #4 clock127 = ~clock127;
	end

	// Checks and reference --------------------
	// Larger count wins, even entry within a half, then the 0x half on equal counts
	function automatic logic [1:0] expected_phase(input int c00, input int c01, input int c10,
		input int c11);
		logic pick_0x;
		logic pick_1x;
		pick_0x = (c01 > c00);
		pick_1x = (c11 > c10);
		if ((pick_1x ? c11 : c10) > (pick_0x ? c01 : c00))
			return {1'b1, pick_1x};
		return {1'b0, pick_0x};
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		assert (got === expected) else begin
			error_count++;
			$display("error at %0t: %s expected %0h, got %0h", $time, name, expected, got);
		end
	endtask

	task automatic check_true(input logic ok, input string what);
		check_count++;
		assert (ok) else begin
			error_count++;
			$display("error at %0t: %s", $time, what);
		end
	endtask

	// Trigger pair expected four cycles after each arrival event
	always @(negedge clock127) begin
		expected_pair = (check_trigger && event_line[3]) ? MARK_PAIR : IDLE_PAIR;
		compare_value("trigger_ddr", trigger_ddr, expected_pair);
		event_line = {event_line[2:0], (revo_word != '0) && (last_word == '0)};
		last_word = revo_word;
	end

	// Stimulus --------------------
	// One marker or noise word, then idle until the next start
	task automatic send_random_marker();
		int idx;
		int hold;
		int spacing;
		hold = $urandom_range(1, 3);
		spacing = $urandom_range(8, 40);
		if ($urandom_range(0, 5) == 0) begin
			// Upper bit clear, so never one of the arrival patterns
			revo_word <= revo_phase_pkg::sample_word_t'($urandom_range(1, 7));
		end else begin
			idx = $urandom_range(0, 3);
			revo_word <= PATTERNS[idx*4 +: 4];
			phase_counts[idx]++;
			pattern_total++;
		end
		repeat (hold) @(posedge clock127);
		revo_word <= '0;
		repeat (spacing - hold) @(posedge clock127);
	endtask

	task automatic check_startup();
		int high_count;
		int i;
		logic ended;
		high_count = 0;
		ended = 1'b0;
		@(negedge clock127);
		compare_value("phase_locked", lock_status.phase_locked, 1'b0);
		compare_value("revo_led", revo_led, 1'b0);
		for (i = 0; i < revo_phase_pkg::STARTUP_CYCLES + 16 && !ended; i++) begin
			if (pll_reset) begin
				high_count++;
				@(negedge clock127);
			end else begin
				ended = 1'b1;
			end
		end
		check_true(ended, "pll_reset stayed high after startup");
		compare_value("pll_reset high cycles", high_count, revo_phase_pkg::STARTUP_CYCLES);
		for (i = 0; i < 100; i++) begin
			@(negedge clock127);
			compare_value("pll_reset", pll_reset, 1'b0);
		end
		@(posedge clock127);
	endtask

	task automatic select_phase();
		logic locked;
		logic [1:0] got_phase;
		int i;
		locked = 1'b0;
		got_phase = '0;
		phase_counts = '{0, 0, 0, 0};
		pattern_total = 0;
		for (i = 0; i < 10 * MIN_MARKERS && pattern_total < MIN_MARKERS; i++)
			send_random_marker();
		@(negedge clock127);
		compare_value("phase_locked", lock_status.phase_locked, 1'b0);
		// This marker pushes the count past the limit
		@(posedge clock127);
		revo_word <= revo_phase_pkg::PATTERN_10;
		@(posedge clock127);
		revo_word <= '0;
		for (i = 0; i < 8 && !locked; i++) begin
			@(negedge clock127);
			locked = lock_status.phase_locked;
			got_phase = lock_status.phase_select;
		end
		check_true(locked, "phase_locked did not rise within 8 cycles of the last marker");
		if (locked)
			compare_value("phase_select", got_phase, expected_phase(phase_counts[0],
				phase_counts[1], phase_counts[2], phase_counts[3]));
		repeat (12) @(posedge clock127);
	endtask

	task automatic wait_for_led(input logic level, input string what);
		logic seen;
		int i;
		seen = 1'b0;
		for (i = 0; i < LED_TIMEOUT && !seen; i++) begin
			@(negedge clock127);
			seen = (revo_led == level);
		end
		check_true(seen, what);
	endtask

	// Next pll_reset pulse, which must last one cycle
	task automatic wait_pll_reset_pulse(input string what);
		logic seen;
		int width;
		int i;
		seen = 1'b0;
		width = 0;
		for (i = 0; i < PULSE_TIMEOUT && !seen; i++) begin
			@(negedge clock127);
			seen = pll_reset;
		end
		check_true(seen, what);
		for (i = 0; i < 8 && pll_reset; i++) begin
			width++;
			@(negedge clock127);
		end
		if (seen)
			compare_value("pll_reset pulse width", width, 1);
	endtask

	task automatic check_lost_lock();
		logic dropped;
		int i;
		dropped = 1'b0;
		pll_locked <= 1'b0;
		for (i = 0; i < 2 && !dropped; i++) begin
			@(negedge clock127);
			dropped = !lock_status.phase_locked;
		end
		check_true(dropped, "phase_locked did not fall within 2 cycles of losing lock");
		wait_pll_reset_pulse("no pll_reset pulse after lock was lost");
		wait_pll_reset_pulse("pll_reset did not repeat while lock stayed low");
		@(posedge clock127);
		pll_locked <= 1'b1;
		repeat (4) @(posedge clock127);
	endtask

	// Test sequence --------------------
	initial begin
		int i;
		void'($urandom(16));
		oserdes_reset = 1'b1;
		revo_word = '0;
		pll_locked = 1'b1;
		repeat (10) @(posedge clock127);
		oserdes_reset <= 1'b0;
		check_startup();
		// Markers start here, so the indicator rises during phase selection
		fork
			select_phase();
			wait_for_led(1'b1, "revo_led did not rise while markers arrived");
		join
		@(posedge clock127);
		check_trigger = 1'b1;
		for (i = 0; i < 30; i++)
			send_random_marker();
		wait_for_led(1'b0, "revo_led did not fall after markers stopped");
		@(posedge clock127);
		check_trigger = 1'b0;
		check_lost_lock();
		select_phase();
		check_trigger = 1'b1;
		for (i = 0; i < 10; i++)
			send_random_marker();
		repeat (8) @(posedge clock127);
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- files.f
revo_phase_pkg.sv
revo_edge_pulser.sv
phase_histogram.sv
revo_lock_control.sv
trigger_encoder.sv
revo_activity_monitor.sv
revo_encoder_top.sv
tb_revo_encoder.sv

//--- Bender.yml
package:
  name: revo_encoder

sources:
  - revo_phase_pkg.sv
  - revo_edge_pulser.sv
  - phase_histogram.sv
  - revo_lock_control.sv
  - trigger_encoder.sv
  - revo_activity_monitor.sv
  - revo_encoder_top.sv
  - target: simulation
    files:
      - tb_revo_encoder.sv
